//--- all.f
verilog/mcPkg.sv
verilog/ctrlIf.sv
verilog/aluUnit.sv
verilog/stateSequencer.sv
verilog/microController.sv
verilog/datapath.sv
verilog/wbMaster.sv
verilog/cpuTop.sv
testbench/tbMemModel.sv
testbench/tbCpu.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f all.f --top-module tbCpu -o simCpu

out=$(./obj_dir/simCpu)
echo "$out"

if echo "$out" | grep -q "Result: PASSED"; then
        exit 0
else
        exit 1
fi

//--- testbench/tbCpu.sv
`timescale 1ns/10ps

module tbCpu;
        localparam int dataW = mcPkg::dataW;
        localparam int cyclesPerInsn = 20;
        localparam int totalInsns = 13 + 8 + 12 + 13;  // Sum of all test programs
        localparam int watchdogCycles = totalInsns * cyclesPerInsn + 4 * 30;

        logic               clk, rstN;
        logic               wbCyc, wbStb, wbWe, wbAck, halt;
        logic [dataW/8-1:0] wbSel;
        logic [dataW-1:0]   wbAdr, wbDatOut, wbDatIn;
        logic [dataW-1:0]   prog[$];
        int errors = 0;
        int checks = 0;

        cpuTop #(.dataW(dataW)) i_dut (
                .clk(clk), .rstN(rstN), .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe),
                .wbSel(wbSel), .wbAdr(wbAdr), .wbDatOut(wbDatOut), .wbDatIn(wbDatIn),
                .wbAck(wbAck), .halt(halt)
        );

        tbMemModel #(.dataW(dataW)) i_mem (
                .clk(clk), .rstN(rstN), .cyc(wbCyc), .stb(wbStb), .we(wbWe), .sel(wbSel),
                .adr(wbAdr), .wrData(wbDatOut), .rdData(wbDatIn), .ack(wbAck)
        );

        initial begin
                clk = 1'b0;
                forever #5 clk = ~clk;
        end

        // RV32I encodings
        function automatic logic [31:0] encI(logic [31:0] imm, logic [4:0] rs1,
                                             logic [2:0] f3, logic [4:0] rd, logic [6:0] op);
                return {imm[11:0], rs1, f3, rd, op};
        endfunction

        function automatic logic [31:0] encR(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
                                             logic [4:0] rs1, logic [4:0] rs2);
                return {f7, rs2, rs1, f3, rd, 7'h33};
        endfunction

        function automatic logic [31:0] encB(logic [31:0] imm, logic [2:0] f3,
                                             logic [4:0] rs1, logic [4:0] rs2);
                return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
        endfunction

        function automatic logic [31:0] encJ(logic [31:0] imm, logic [4:0] rd);
                return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
        endfunction

        function automatic logic [31:0] addi(logic [4:0] rd, logic [4:0] rs1, logic [31:0] imm);
                return encI(imm, rs1, 3'd0, rd, 7'h13);
        endfunction

        function automatic logic [31:0] lw(logic [4:0] rd, logic [31:0] imm);
                return encI(imm, 5'd0, 3'd2, rd, 7'h03);
        endfunction

        function automatic logic [31:0] sw(logic [4:0] rs2, logic [31:0] imm);
                return {imm[11:5], rs2, 5'd0, 3'd2, imm[4:0], 7'h23};
        endfunction

        task automatic checkWord(input string name, input logic [dataW-1:0] got,
                                 input logic [dataW-1:0] exp);
                checks++;
                if (got !== exp) begin
                        $display("ERR %s got %h expected %h", name, got, exp);
                        errors++;
                end
        endtask

        task automatic checkBus(input logic ok, input string what);
                if (!ok) begin
                        $display("Bus error: %s at %0t", what, $time);
                        errors++;
                end
        endtask

        // Request must stay frozen until ack
        logic               pend = 1'b0;
        logic [dataW-1:0]   lastAdr, lastDat;
        logic               lastWe;
        always @(posedge clk) begin
                if (rstN) begin
                        checkBus(!(wbStb && !wbCyc), "stb high without cyc");
                        if (pend)
                                checkBus(wbCyc && wbStb && wbAdr == lastAdr && wbWe == lastWe &&
                                         wbDatOut == lastDat && wbSel == '1,
                                         "request changed before ack");
                end
                pend    = rstN && wbCyc && wbStb && !wbAck;
                lastAdr = wbAdr;
                lastDat = wbDatOut;
                lastWe  = wbWe;
        end

        task automatic runProgram(input string name, input int nInsn);
                int cnt;
                #1 rstN = 1'b0;
                i_mem.fillAll();
                for (int i = 0; i < prog.size(); i++)
                        i_mem.writeWord(dataW'(i * 4), prog[i]);
                repeat (5) @(posedge clk);
                #1 rstN = 1'b1;
                cnt = 0;
                while (!halt && cnt < nInsn * cyclesPerInsn) begin
                        @(posedge clk);
                        cnt++;
                end
                if (!halt) begin
                        $display("Program %s did not halt in %0d cycles", name, cnt);
                        errors++;
                end
                repeat (10) begin
                        @(posedge clk);
                        checkBus(!wbCyc, "bus cycle started after halt");
                end
        endtask

        task automatic finishTest(input string name, input int errBefore);
                if (errors == errBefore)
                        $display("Test %s: ok", name);
                else
                        $display("Test %s: %0d errors", name, errors - errBefore);
        endtask

        task automatic testAlu();
                int a = 7;
                int b = -3;
                int e0 = errors;
                prog = {addi(1, 0, 7), addi(2, 0, -3),
                        encR(0, 0, 3, 1, 2), encR(7'h20, 0, 4, 1, 2), encR(0, 7, 5, 1, 2),
                        encR(0, 6, 6, 1, 2), encR(0, 2, 7, 2, 1),
                        sw(3, 'h100), sw(4, 'h104), sw(5, 'h108), sw(6, 'h10c), sw(7, 'h110),
                        32'h73};
                runProgram("alu", 13);
                checkWord("add", i_mem.peekWord('h100), a + b);
                checkWord("sub", i_mem.peekWord('h104), a - b);
                checkWord("and", i_mem.peekWord('h108), a & b);
                checkWord("or", i_mem.peekWord('h10c), a | b);
                checkWord("slt", i_mem.peekWord('h110), (b < a) ? 1 : 0);
                finishTest("alu", e0);
        endtask

        task automatic testLoadStore();
                int e0 = errors;
                prog = {addi(1, 0, 'h123), sw(1, 'h100), lw(2, 'h100), addi(3, 2, 5),
                        sw(3, 'h104), addi(0, 0, 9), sw(0, 'h108), 32'h73};
                runProgram("loadStore", 8);
                checkWord("mem100", i_mem.peekWord('h100), 'h123);
                checkWord("mem104", i_mem.peekWord('h104), 'h128);
                checkWord("x0", i_mem.peekWord('h108), 0);
                finishTest("loadStore", e0);
        endtask

        task automatic testBranch();
                int e0 = errors;
                prog = {addi(1, 0, 1), addi(2, 0, 1), addi(5, 0, 'haa),
                        encB(8, 0, 1, 2), sw(5, 'h100),         // beq taken
                        encB(8, 1, 1, 2), sw(5, 'h104),         // bne not taken
                        encB(8, 0, 1, 0), sw(5, 'h108),
                        encB(8, 1, 1, 0), sw(5, 'h10c),
                        32'h73};
                runProgram("branch", 12);
                checkWord("beqTaken", i_mem.peekWord('h100), i_mem.fillWord('h100));
                checkWord("bneUntaken", i_mem.peekWord('h104), 'haa);
                checkWord("beqUntaken", i_mem.peekWord('h108), 'haa);
                checkWord("bneTaken", i_mem.peekWord('h10c), i_mem.fillWord('h10c));
                finishTest("branch", e0);
        endtask

        task automatic testJump();
                int e0 = errors;
                prog = {addi(5, 0, 'h55), encJ(12, 1), sw(5, 'h100), sw(5, 'h104),
                        sw(1, 'h108), addi(6, 0, 'h29), encI(0, 6, 0, 7, 7'h67),
                        sw(5, 'h10c), sw(5, 'h110), 32'h73,
                        sw(7, 'h114), sw(5, 'h118), 32'h73};
                runProgram("jump", 13);
                checkWord("jalSkip0", i_mem.peekWord('h100), i_mem.fillWord('h100));
                checkWord("jalSkip1", i_mem.peekWord('h104), i_mem.fillWord('h104));
                checkWord("jalLink", i_mem.peekWord('h108), 'h8);
                checkWord("jalrSkip0", i_mem.peekWord('h10c), i_mem.fillWord('h10c));
                checkWord("jalrSkip1", i_mem.peekWord('h110), i_mem.fillWord('h110));
                checkWord("jalrLink", i_mem.peekWord('h114), 'h1c);
                checkWord("jalrLand", i_mem.peekWord('h118), 'h55);
                finishTest("jump", e0);
        endtask

        initial begin
                void'($urandom(49970));
                rstN = 1'b0;
                testAlu();
                testLoadStore();
                testBranch();
                testJump();
                $display("Tests 4, checks %0d, errors %0d", checks, errors);
                if (errors == 0)
                        $display("Result: PASSED");
                else
                        $display("Result: FAILED");
                $finish;
        end

        initial begin
                repeat (watchdogCycles) @(posedge clk);
                $display("Watchdog expired, the run took too long");
                $display("Result: FAILED");
                $finish;
        end
endmodule

//--- testbench/tbMemModel.sv
`timescale 1ns/10ps

module tbMemModel #(
        parameter int dataW = 32,
        parameter int depth = 1024
) (
        input  logic               clk,
        input  logic               rstN,
        input  logic               cyc,
        input  logic               stb,
        input  logic               we,
        input  logic [dataW/8-1:0] sel,
        input  logic [dataW-1:0]   adr,
        input  logic [dataW-1:0]   wrData,
        output logic [dataW-1:0]   rdData,
        output logic               ack
);
        localparam int idxW = $clog2(depth);

        logic [dataW-1:0] mem [depth];
        int waitLeft;

        function automatic void writeWord(input logic [dataW-1:0] addr,
                                          input logic [dataW-1:0] data);
                mem[addr[idxW+1:2]] = data;
        endfunction

        function automatic logic [dataW-1:0] peekWord(input logic [dataW-1:0] addr);
                return mem[addr[idxW+1:2]];
        endfunction

        // Unwritten words read back as a tag mixed with their address
        function automatic logic [dataW-1:0] fillWord(input logic [dataW-1:0] addr);
                return addr ^ dataW'(32'hdead0000);
        endfunction

        function automatic void fillAll();
                for (int i = 0; i < depth; i++)
                        mem[i] = fillWord(dataW'(i * 4));
        endfunction

        initial begin
                ack      = 1'b0;
                rdData   = '0;
                waitLeft = 0;
        end

        // Ack after 1 to 3 cycles, one cycle wide
        always @(posedge clk) begin
                #1;
                if (!rstN) begin
                        ack = 1'b0;
                end else if (ack) begin
                        ack = 1'b0;
                end else if (cyc && stb) begin
                        if (waitLeft == 0) begin
                                ack    = 1'b1;
                                rdData = mem[adr[idxW+1:2]];
                                if (we && sel == '1)
                                        mem[adr[idxW+1:2]] = wrData;
                                waitLeft = $urandom % 3;
                        end else begin
                                waitLeft--;
                        end
                end
        end
endmodule

//--- verilog/aluUnit.sv
`timescale 1ns/10ps

module aluUnit #(
        parameter int dataW = mcPkg::dataW
) (
        input  mcPkg::aluOpT     aluOp,
        input  logic [2:0]       funct3,
        input  logic             funct7b5,
        input  logic             isImm,
        input  logic [dataW-1:0] opA,
        input  logic [dataW-1:0] opB,
        output logic [dataW-1:0] result,
        output logic             zero
);
        logic [dataW-1:0] sum;
        logic [dataW-1:0] diff;

        assign sum  = opA + opB;
        assign diff = opA - opB;

        always_comb begin
                result = sum;
                if (aluOp == mcPkg::SUB) begin
                        result = diff;
                end else if (aluOp == mcPkg::FUNCT) begin
                        case (funct3)
                        3'b000:  result = (funct7b5 && !isImm) ? diff : sum;  // addi has no sub
                        3'b010:  result = {{(dataW-1){1'b0}}, $signed(opA) < $signed(opB)};
                        3'b110:  result = opA | opB;
                        3'b111:  result = opA & opB;
                        default: result = sum;
                        endcase
                end
        end

        assign zero = (result == '0);
endmodule

//--- verilog/cpuTop.sv
`timescale 1ns/10ps

module cpuTop #(
        parameter int dataW = mcPkg::dataW
) (
        input  logic               clk,
        input  logic               rstN,
        output logic               wbCyc,
        output logic               wbStb,
        output logic               wbWe,
        output logic [dataW/8-1:0] wbSel,
        output logic [dataW-1:0]   wbAdr,
        output logic [dataW-1:0]   wbDatOut,
        input  logic [dataW-1:0]   wbDatIn,
        input  logic               wbAck,
        output logic               halt
);
        mcPkg::cycleStateT state;
        mcPkg::opcodeT     opcode;
        logic              memRead, memWrite, memDone;
        logic [dataW-1:0]  adr, wrData, rdData;

        ctrlIf ctrl ();

        stateSequencer i_seq (
                .clk     (clk),
                .rstN    (rstN),
                .opcode  (opcode),
                .memDone (memDone),
                .ctrl    (ctrl.stepSrc),
                .state   (state)
        );

        microController i_mc (
                .state    (state),
                .opcode   (opcode),
                .ctrl     (ctrl.ctrlSrc),
                .memRead  (memRead),
                .memWrite (memWrite),
                .halt     (halt)
        );

        datapath #(.dataW(dataW)) i_dp (
                .clk    (clk),
                .rstN   (rstN),
                .ctrl   (ctrl.ctrlSink),
                .rdData (rdData),
                .adr    (adr),
                .wrData (wrData),
                .opcode (opcode)
        );

        wbMaster #(.dataW(dataW)) i_wb (
                .clk      (clk),
                .rstN     (rstN),
                .memRead  (memRead),
                .memWrite (memWrite),
                .adrIn    (adr),
                .wrData   (wrData),
                .memDone  (memDone),
                .rdData   (rdData),
                .wbCyc    (wbCyc),
                .wbStb    (wbStb),
                .wbWe     (wbWe),
                .wbSel    (wbSel),
                .wbAdr    (wbAdr),
                .wbDatOut (wbDatOut),
                .wbDatIn  (wbDatIn),
                .wbAck    (wbAck)
        );
endmodule

//--- verilog/ctrlIf.sv
`timescale 1ns/10ps

interface ctrlIf;
        logic         pcWrite;
        logic         pcWriteCond;
        logic         iOrD;
        logic         irWrite;
        mcPkg::wbSelT memToReg;
        logic         pcSource;         // 0 pcPlus4, 1 ALUOut
        mcPkg::aluOpT aluOp;
        logic         aluSrcA;          // 0 PC, 1 A
        mcPkg::srcBT  aluSrcB;
        logic         regWrite;
        logic         aluOutUpdate;
        logic         stepEn;

        modport ctrlSrc (output pcWrite, pcWriteCond, iOrD, irWrite, memToReg, pcSource,
                         aluOp, aluSrcA, aluSrcB, regWrite, aluOutUpdate);

        modport stepSrc (output stepEn);

        modport ctrlSink (input pcWrite, pcWriteCond, iOrD, irWrite, memToReg, pcSource,
                          aluOp, aluSrcA, aluSrcB, regWrite, aluOutUpdate, stepEn);
endinterface

//--- verilog/datapath.sv
`timescale 1ns/10ps

module datapath #(
        parameter int dataW = mcPkg::dataW
) (
        input  logic             clk,
        input  logic             rstN,
        ctrlIf.ctrlSink          ctrl,
        input  logic [dataW-1:0] rdData,
        output logic [dataW-1:0] adr,
        output logic [dataW-1:0] wrData,
        output mcPkg::opcodeT    opcode
);
        logic [dataW-1:0] pc, pcPlus4, ir, mdr, regA, regB, aluOut;
        logic [dataW-1:0] regFile [32];
        logic [dataW-1:0] imm, srcA, srcB, aluResult, wbData, pcNext;
        logic [4:0]       rs1, rs2, rd;
        logic             zero, taken;

        assign opcode = mcPkg::opcodeT'(ir[6:0]);
        assign rs1    = ir[19:15];
        assign rs2    = ir[24:20];
        assign rd     = ir[11:7];

        always_comb begin
                case (opcode)
                mcPkg::STORE:  imm = {{(dataW-12){ir[31]}}, ir[31:25], ir[11:7]};
                mcPkg::BRANCH: imm = {{(dataW-12){ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
                mcPkg::JAL:    imm = {{(dataW-20){ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};
                default:       imm = {{(dataW-12){ir[31]}}, ir[31:20]};
                endcase
        end

        assign srcA = ctrl.aluSrcA ? regA : pc;

        always_comb begin
                case (ctrl.aluSrcB)
                mcPkg::FOUR: srcB = dataW'(4);
                mcPkg::IMM:  srcB = imm;
                default:     srcB = regB;
                endcase
        end

        aluUnit #(.dataW(dataW)) i_alu (
                .aluOp    (ctrl.aluOp),
                .funct3   (ir[14:12]),
                .funct7b5 (ir[30]),
                .isImm    (opcode == mcPkg::ARITH_IMM),
                .opA      (srcA),
                .opB      (srcB),
                .result   (aluResult),
                .zero     (zero)
        );

        always_comb begin
                case (ctrl.memToReg)
                mcPkg::MDR:     wbData = mdr;
                mcPkg::PCPLUS4: wbData = pcPlus4;
                default:        wbData = aluOut;
                endcase
        end

        assign taken  = zero ^ ir[12];  // beq on zero, bne otherwise
        assign pcNext = (ctrl.pcSource && (!ctrl.pcWriteCond || taken)) ?
                        {aluOut[dataW-1:1], 1'b0} : pcPlus4;

        assign adr    = ctrl.iOrD ? aluOut : pc;
        assign wrData = regB;

        always_ff @(posedge clk) begin
                if (!rstN)
                        pc <= '0;
                else if (ctrl.stepEn && (ctrl.pcWrite || ctrl.pcWriteCond))
                        pc <= pcNext;
        end

        always_ff @(posedge clk) begin
                if (ctrl.stepEn) begin
                        regA <= (rs1 == 5'd0) ? '0 : regFile[rs1];
                        regB <= (rs2 == 5'd0) ? '0 : regFile[rs2];
                        if (ctrl.irWrite) begin
                                ir      <= rdData;
                                pcPlus4 <= aluResult;
                        end
                        if (ctrl.iOrD)
                                mdr <= rdData;
                        if (ctrl.aluOutUpdate)
                                aluOut <= aluResult;
                        if (ctrl.regWrite && rd != 5'd0)
                                regFile[rd] <= wbData;
                end
        end
endmodule

//--- verilog/mcPkg.sv
package mcPkg;

        parameter int dataW = 32;

        typedef enum logic [2:0] {
                IF,
                ID,
                EX,
                MEM,
                WB,
                HALT
        } cycleStateT;

        // RV32I major opcodes
        typedef enum logic [6:0] {
                ARITH     = 7'b0110011,
                ARITH_IMM = 7'b0010011,
                LOAD      = 7'b0000011,
                STORE     = 7'b0100011,
                BRANCH    = 7'b1100011,
                JAL       = 7'b1101111,
                JALR      = 7'b1100111,
                SYSTEM    = 7'b1110011
        } opcodeT;

        typedef enum logic [1:0] {
                ADD,
                SUB,
                FUNCT           // Decode from funct3/funct7
        } aluOpT;

        typedef enum logic [1:0] {REGB, FOUR, IMM} srcBT;

        typedef enum logic [1:0] {ALUOUT, MDR, PCPLUS4} wbSelT;

endpackage

//--- verilog/microController.sv
`timescale 1ns/10ps

module microController (
        input  mcPkg::cycleStateT state,
        input  mcPkg::opcodeT     opcode,
        ctrlIf.ctrlSrc            ctrl,
        output logic              memRead,
        output logic              memWrite,
        output logic              halt
);
        always_comb begin
                ctrl.pcWrite      = 1'b0;
                ctrl.pcWriteCond  = 1'b0;
                ctrl.iOrD         = 1'b0;
                ctrl.irWrite      = 1'b0;
                ctrl.memToReg     = mcPkg::ALUOUT;
                ctrl.pcSource     = 1'b0;
                ctrl.aluOp        = mcPkg::ADD;
                ctrl.aluSrcA      = 1'b0;
                ctrl.aluSrcB      = mcPkg::REGB;
                ctrl.regWrite     = 1'b0;
                ctrl.aluOutUpdate = 1'b0;
                memRead           = 1'b0;
                memWrite          = 1'b0;
                halt              = 1'b0;

                case (state)
                mcPkg::IF: begin
                        memRead      = 1'b1;
                        ctrl.irWrite = 1'b1;
                        ctrl.aluSrcB = mcPkg::FOUR;     // PC+4 into pcPlus4
                end
                mcPkg::ID: begin
                        ctrl.aluSrcB      = mcPkg::IMM; // Branch or jal target
                        ctrl.aluOutUpdate = 1'b1;
                end
                mcPkg::EX: begin
                        ctrl.aluSrcA      = 1'b1;
                        ctrl.aluSrcB      = mcPkg::IMM;
                        ctrl.aluOutUpdate = 1'b1;
                        case (opcode)
                        mcPkg::ARITH: begin
                                ctrl.aluOp   = mcPkg::FUNCT;
                                ctrl.aluSrcB = mcPkg::REGB;
                        end
                        mcPkg::ARITH_IMM: ctrl.aluOp = mcPkg::FUNCT;
                        mcPkg::BRANCH: begin
                                // Compare only, keep the target in ALUOut
                                ctrl.aluOp        = mcPkg::SUB;
                                ctrl.aluSrcB      = mcPkg::REGB;
                                ctrl.aluOutUpdate = 1'b0;
                                ctrl.pcWriteCond  = 1'b1;
                                ctrl.pcSource     = 1'b1;
                        end
                        default: begin
                        end
                        endcase
                end
                mcPkg::MEM: begin
                        ctrl.iOrD = 1'b1;
                        if (opcode == mcPkg::STORE) begin
                                memWrite     = 1'b1;
                                ctrl.pcWrite = 1'b1;    // Store ends here
                        end else begin
                                memRead = 1'b1;
                        end
                end
                mcPkg::WB: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.pcWrite  = 1'b1;
                        case (opcode)
                        mcPkg::LOAD: ctrl.memToReg = mcPkg::MDR;
                        mcPkg::JAL, mcPkg::JALR: begin
                                ctrl.memToReg = mcPkg::PCPLUS4;   // Link
                                ctrl.pcSource = 1'b1;
                        end
                        default: ctrl.memToReg = mcPkg::ALUOUT;
                        endcase
                end
                mcPkg::HALT: halt = 1'b1;
                default: begin
                end
                endcase
        end
endmodule

//--- verilog/stateSequencer.sv
`timescale 1ns/10ps

module stateSequencer (
        input  logic              clk,
        input  logic              rstN,
        input  mcPkg::opcodeT     opcode,
        input  logic              memDone,
        ctrlIf.stepSrc            ctrl,
        output mcPkg::cycleStateT state
);
        mcPkg::cycleStateT nextState;
        logic memWait;

        // Fetch and MEM hold until the bus acks
        assign memWait = (state == mcPkg::IF) || (state == mcPkg::MEM);
        assign ctrl.stepEn = memWait ? memDone : (state != mcPkg::HALT);

        always_comb begin
                nextState = state;
                case (state)
                mcPkg::IF:  nextState = mcPkg::ID;
                mcPkg::ID: begin
                        case (opcode)
                        mcPkg::JAL: nextState = mcPkg::WB;     // Target already in ALUOut
                        mcPkg::ARITH, mcPkg::ARITH_IMM, mcPkg::LOAD,
                        mcPkg::STORE, mcPkg::BRANCH, mcPkg::JALR: nextState = mcPkg::EX;
                        default: nextState = mcPkg::HALT;      // ecall and unknown opcodes
                        endcase
                end
                mcPkg::EX: begin
                        if (opcode == mcPkg::LOAD || opcode == mcPkg::STORE)
                                nextState = mcPkg::MEM;
                        else if (opcode == mcPkg::BRANCH)
                                nextState = mcPkg::IF;
                        else
                                nextState = mcPkg::WB;
                end
                mcPkg::MEM: nextState = (opcode == mcPkg::LOAD) ? mcPkg::WB : mcPkg::IF;
                mcPkg::WB:  nextState = mcPkg::IF;
                default:    nextState = mcPkg::HALT;
                endcase
        end

        always_ff @(posedge clk) begin
                if (!rstN)
                        state <= mcPkg::IF;
                else if (ctrl.stepEn)
                        state <= nextState;
        end
endmodule

//--- verilog/wbMaster.sv
`timescale 1ns/10ps

module wbMaster #(
        parameter int dataW = mcPkg::dataW
) (
        input  logic               clk,
        input  logic               rstN,
        input  logic               memRead,
        input  logic               memWrite,
        input  logic [dataW-1:0]   adrIn,
        input  logic [dataW-1:0]   wrData,
        output logic               memDone,
        output logic [dataW-1:0]   rdData,
        output logic               wbCyc,
        output logic               wbStb,
        output logic               wbWe,
        output logic [dataW/8-1:0] wbSel,
        output logic [dataW-1:0]   wbAdr,
        output logic [dataW-1:0]   wbDatOut,
        input  logic [dataW-1:0]   wbDatIn,
        input  logic               wbAck
);
        always_ff @(posedge clk) begin
                if (!rstN) begin
                        wbCyc <= 1'b0;
                        wbWe  <= 1'b0;
                end else if (wbCyc) begin
                        if (wbAck) begin
                                wbCyc <= 1'b0;  // Bus idles one cycle after ack
                                wbWe  <= 1'b0;
                        end
                end else if (memRead || memWrite) begin
                        wbCyc <= 1'b1;
                        wbWe  <= memWrite;
                end
        end

        // Frozen for the whole bus cycle
        always_ff @(posedge clk) begin
                if (!wbCyc) begin
                        wbAdr    <= adrIn;
                        wbDatOut <= wrData;
                end
        end

        assign wbStb   = wbCyc;
        assign wbSel   = '1;            // Word accesses only
        assign memDone = wbCyc && wbAck;
        assign rdData  = wbDatIn;       // Slave data valid in the ack cycle
endmodule
